// ==== rtl/riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_SW      = 3'b010;

    localparam logic [2:0] F3_DOT  = 3'b000;
    localparam logic [2:0] F3_RELU = 3'b010;
    localparam logic [2:0] F3_STEP = 3'b100;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    typedef union packed {
        struct packed {
            logic [6:0]            funct7; // imm[11:5] in I-type
            logic [REG_ADDR_W-1:0] rs2;    // imm[4:0] in I-type
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } ri;
        struct packed {
            logic [6:0]            imm_hi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
    } instr_t;

endpackage

`default_nettype wire

// ==== rtl/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam logic [31:0] PC_STEP  = 32'd4;

    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_DOT  = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_RELU = 3'd6;
    localparam logic [ALU_OP_W-1:0] ALU_STEP = 3'd7;

    localparam int FWD_W = 2;

    localparam logic [FWD_W-1:0] FWD_NONE = 2'd0;
    localparam logic [FWD_W-1:0] FWD_MEM  = 2'd1; // From EX/MEM
    localparam logic [FWD_W-1:0] FWD_WB   = 2'd2; // From MEM/WB

endpackage

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           freeze,
    input  logic [riscv_isa_pkg::XLEN-1:0] imem_data,
    output logic [riscv_isa_pkg::XLEN-1:0] imem_addr,
    output riscv_isa_pkg::instr_t          if_instr,
    output logic                           if_valid
);

    // PC and IF/ID advance together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            imem_addr <= core_cfg_pkg::RESET_PC;
            if_instr  <= riscv_isa_pkg::NOP_INSTR;
            if_valid  <= 1'b0;
        end else if (!freeze) begin
            imem_addr <= imem_addr + core_cfg_pkg::PC_STEP;
            if_instr  <= imem_data;
            if_valid  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 freeze,
    input  riscv_isa_pkg::instr_t                if_instr,
    input  logic                                 if_valid,
    input  logic [riscv_isa_pkg::XLEN-1:0]       rs1_data,
    input  logic [riscv_isa_pkg::XLEN-1:0]       rs2_data,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rs1,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rs2,
    output logic [riscv_isa_pkg::XLEN-1:0]       ex_rs1_data,
    output logic [riscv_isa_pkg::XLEN-1:0]       ex_rs2_data,
    output logic [riscv_isa_pkg::XLEN-1:0]       ex_imm,
    output logic                                 ex_use_imm,
    output logic [core_cfg_pkg::ALU_OP_W-1:0]    ex_alu_op,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic                                 ex_reg_write,
    output logic                                 ex_store
);

    logic [riscv_isa_pkg::XLEN-1:0]    imm;
    logic                              use_imm;
    logic [core_cfg_pkg::ALU_OP_W-1:0] alu_op;
    logic                              reg_write;
    logic                              store;

    assign rs1_addr = if_instr.ri.rs1;
    assign rs2_addr = if_instr.ri.rs2;

    always_comb begin
        imm       = {{20{if_instr.ri.funct7[6]}}, if_instr.ri.funct7, if_instr.ri.rs2};
        use_imm   = 1'b0;
        alu_op    = core_cfg_pkg::ALU_ADD;
        reg_write = 1'b0;
        store     = 1'b0;
        case (if_instr.ri.opcode)
            riscv_isa_pkg::OPC_OP, riscv_isa_pkg::OPC_OP_IMM: begin
                use_imm   = (if_instr.ri.opcode == riscv_isa_pkg::OPC_OP_IMM);
                reg_write = 1'b1;
                case (if_instr.ri.funct3)
                    riscv_isa_pkg::F3_ADD_SUB: begin
                        if (!use_imm && if_instr.ri.funct7 == riscv_isa_pkg::F7_SUB) begin
                            alu_op = core_cfg_pkg::ALU_SUB;
                        end
                    end
                    riscv_isa_pkg::F3_XOR: alu_op = core_cfg_pkg::ALU_XOR;
                    riscv_isa_pkg::F3_OR:  alu_op = core_cfg_pkg::ALU_OR;
                    riscv_isa_pkg::F3_AND: alu_op = core_cfg_pkg::ALU_AND;
                    default: reg_write = 1'b0; // Shifts and compares not supported
                endcase
            end
            riscv_isa_pkg::OPC_STORE: begin
                imm     = {{20{if_instr.s.imm_hi[6]}}, if_instr.s.imm_hi, if_instr.s.imm_lo};
                use_imm = 1'b1;
                store   = (if_instr.s.funct3 == riscv_isa_pkg::F3_SW);
            end
            riscv_isa_pkg::OPC_CUSTOM0: begin
                reg_write = 1'b1;
                case (if_instr.ri.funct3)
                    riscv_isa_pkg::F3_DOT:  alu_op = core_cfg_pkg::ALU_DOT;
                    riscv_isa_pkg::F3_RELU: alu_op = core_cfg_pkg::ALU_RELU;
                    riscv_isa_pkg::F3_STEP: alu_op = core_cfg_pkg::ALU_STEP;
                    default: reg_write = 1'b0;
                endcase
            end
            default: ; // Anything else is a no-op
        endcase
        if (!if_valid || if_instr.ri.rd == '0) begin
            reg_write = 1'b0;
        end
        if (!if_valid) begin
            store = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_reg_write <= 1'b0;
            ex_store     <= 1'b0;
        end else if (!freeze) begin
            ex_reg_write <= reg_write;
            ex_store     <= store;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            ex_rs1      <= if_instr.ri.rs1;
            ex_rs2      <= if_instr.ri.rs2;
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
            ex_imm      <= imm;
            ex_use_imm  <= use_imm;
            ex_alu_op   <= alu_op;
            ex_rd       <= if_instr.ri.rd;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] rf_wr_addr,
    input  logic                                 rf_wr_en,
    input  logic [riscv_isa_pkg::XLEN-1:0]       rf_wr_data,
    output logic [riscv_isa_pkg::XLEN-1:0]       rs1_data,
    output logic [riscv_isa_pkg::XLEN-1:0]       rs2_data
);

    logic [riscv_isa_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage

    function automatic logic [riscv_isa_pkg::XLEN-1:0] read_port(
        input logic [riscv_isa_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (rf_wr_en && rf_wr_addr == addr) begin
            return rf_wr_data; // Write-through
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr_en && rf_wr_addr != '0) begin
            regs[rf_wr_addr] <= rf_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 freeze,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rs1,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rs2,
    input  logic [riscv_isa_pkg::XLEN-1:0]       ex_rs1_data,
    input  logic [riscv_isa_pkg::XLEN-1:0]       ex_rs2_data,
    input  logic [riscv_isa_pkg::XLEN-1:0]       ex_imm,
    input  logic                                 ex_use_imm,
    input  logic [core_cfg_pkg::ALU_OP_W-1:0]    ex_alu_op,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic                                 ex_reg_write,
    input  logic                                 ex_store,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] rf_wr_addr,
    input  logic                                 rf_wr_en,
    input  logic [riscv_isa_pkg::XLEN-1:0]       rf_wr_data,
    output logic [riscv_isa_pkg::XLEN-1:0]       mem_result,
    output logic [riscv_isa_pkg::XLEN-1:0]       mem_store_data,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] mem_rd,
    output logic                                 mem_reg_write,
    output logic                                 mem_store
);

    logic [core_cfg_pkg::FWD_W-1:0]          sel_a;
    logic [core_cfg_pkg::FWD_W-1:0]          sel_b;
    logic [riscv_isa_pkg::XLEN-1:0]          op_a;
    logic [riscv_isa_pkg::XLEN-1:0]          op_b;
    logic [riscv_isa_pkg::XLEN-1:0]          store_val;
    logic signed [2*riscv_isa_pkg::XLEN-1:0] product;
    logic [riscv_isa_pkg::XLEN-1:0]          alu_out;

    // Youngest producer wins, bubbles never match since their write flag is 0
    function automatic logic [core_cfg_pkg::FWD_W-1:0] fwd_sel(
        input logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs
    );
        if (rs == '0) begin
            return core_cfg_pkg::FWD_NONE;
        end else if (mem_reg_write && mem_rd == rs) begin
            return core_cfg_pkg::FWD_MEM;
        end else if (rf_wr_en && rf_wr_addr == rs) begin
            return core_cfg_pkg::FWD_WB;
        end
        return core_cfg_pkg::FWD_NONE;
    endfunction

    function automatic logic [riscv_isa_pkg::XLEN-1:0] fwd_mux(
        input logic [core_cfg_pkg::FWD_W-1:0] sel,
        input logic [riscv_isa_pkg::XLEN-1:0] id_val
    );
        case (sel)
            core_cfg_pkg::FWD_MEM: return mem_result;
            core_cfg_pkg::FWD_WB:  return rf_wr_data;
            default:               return id_val;
        endcase
    endfunction

    always_comb begin
        sel_a     = fwd_sel(ex_rs1);
        sel_b     = fwd_sel(ex_rs2);
        op_a      = fwd_mux(sel_a, ex_rs1_data);
        store_val = fwd_mux(sel_b, ex_rs2_data);
        op_b      = ex_use_imm ? ex_imm : store_val;
        product   = $signed(op_a) * $signed(op_b);
        case (ex_alu_op)
            core_cfg_pkg::ALU_ADD:  alu_out = op_a + op_b;
            core_cfg_pkg::ALU_SUB:  alu_out = op_a - op_b;
            core_cfg_pkg::ALU_AND:  alu_out = op_a & op_b;
            core_cfg_pkg::ALU_OR:   alu_out = op_a | op_b;
            core_cfg_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            core_cfg_pkg::ALU_DOT:  alu_out = product[riscv_isa_pkg::XLEN-1:0];
            core_cfg_pkg::ALU_RELU: alu_out = op_a[riscv_isa_pkg::XLEN-1] ? '0 : op_a;
            core_cfg_pkg::ALU_STEP: begin
                alu_out = {{(riscv_isa_pkg::XLEN-1){1'b0}}, ~op_a[riscv_isa_pkg::XLEN-1]};
            end
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_reg_write <= 1'b0;
            mem_store     <= 1'b0;
        end else if (!freeze) begin
            mem_reg_write <= ex_reg_write;
            mem_store     <= ex_store;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            mem_result     <= alu_out; // Store address for SW
            mem_store_data <= store_val;
            mem_rd         <= ex_rd;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [riscv_isa_pkg::XLEN-1:0]       mem_result,
    input  logic [riscv_isa_pkg::XLEN-1:0]       mem_store_data,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic                                 mem_reg_write,
    input  logic                                 mem_store,
    input  logic                                 wb_ack,
    output logic                                 wb_cyc,
    output logic                                 wb_stb,
    output logic [riscv_isa_pkg::XLEN-1:0]       wb_adr,
    output logic [riscv_isa_pkg::XLEN-1:0]       wb_dat,
    output logic                                 freeze,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0] rf_wr_addr,
    output logic                                 rf_wr_en,
    output logic [riscv_isa_pkg::XLEN-1:0]       rf_wr_data
);

    // Write cycle lasts as long as the store sits in EX/MEM
    assign wb_cyc = mem_store;
    assign wb_stb = mem_store;
    assign wb_adr = mem_result;
    assign wb_dat = mem_store_data;
    assign freeze = mem_store & ~wb_ack; // Whole pipeline waits on the slave

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rf_wr_en <= 1'b0;
        end else if (!freeze) begin
            rf_wr_en <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            rf_wr_addr <= mem_rd;
            rf_wr_data <= mem_result;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/riscv_ai_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_ai_core (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [riscv_isa_pkg::XLEN-1:0] imem_data,
    input  logic                           wb_ack,
    output logic [riscv_isa_pkg::XLEN-1:0] imem_addr,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic [riscv_isa_pkg::XLEN-1:0] wb_adr,
    output logic [riscv_isa_pkg::XLEN-1:0] wb_dat
);

    logic                                 freeze;
    riscv_isa_pkg::instr_t                if_instr;
    logic                                 if_valid;
    logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [riscv_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [riscv_isa_pkg::XLEN-1:0]       rs1_data;
    logic [riscv_isa_pkg::XLEN-1:0]       rs2_data;
    logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rs1;
    logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rs2;
    logic [riscv_isa_pkg::XLEN-1:0]       ex_rs1_data;
    logic [riscv_isa_pkg::XLEN-1:0]       ex_rs2_data;
    logic [riscv_isa_pkg::XLEN-1:0]       ex_imm;
    logic                                 ex_use_imm;
    logic [core_cfg_pkg::ALU_OP_W-1:0]    ex_alu_op;
    logic [riscv_isa_pkg::REG_ADDR_W-1:0] ex_rd;
    logic                                 ex_reg_write;
    logic                                 ex_store;
    logic [riscv_isa_pkg::XLEN-1:0]       mem_result;
    logic [riscv_isa_pkg::XLEN-1:0]       mem_store_data;
    logic [riscv_isa_pkg::REG_ADDR_W-1:0] mem_rd;
    logic                                 mem_reg_write;
    logic                                 mem_store;
    logic [riscv_isa_pkg::REG_ADDR_W-1:0] rf_wr_addr;
    logic                                 rf_wr_en;
    logic [riscv_isa_pkg::XLEN-1:0]       rf_wr_data;

    fetch_stage u_fetch (
        .clk(clk), .reset(reset), .freeze(freeze), .imem_data(imem_data),
        .imem_addr(imem_addr), .if_instr(if_instr), .if_valid(if_valid)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset), .freeze(freeze),
        .if_instr(if_instr), .if_valid(if_valid),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_use_imm(ex_use_imm), .ex_alu_op(ex_alu_op),
        .ex_rd(ex_rd), .ex_reg_write(ex_reg_write), .ex_store(ex_store)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rf_wr_addr(rf_wr_addr), .rf_wr_en(rf_wr_en), .rf_wr_data(rf_wr_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset), .freeze(freeze),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_use_imm(ex_use_imm), .ex_alu_op(ex_alu_op),
        .ex_rd(ex_rd), .ex_reg_write(ex_reg_write), .ex_store(ex_store),
        .rf_wr_addr(rf_wr_addr), .rf_wr_en(rf_wr_en), .rf_wr_data(rf_wr_data),
        .mem_result(mem_result), .mem_store_data(mem_store_data), .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write), .mem_store(mem_store)
    );

    mem_stage u_mem (
        .clk(clk), .reset(reset),
        .mem_result(mem_result), .mem_store_data(mem_store_data), .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write), .mem_store(mem_store), .wb_ack(wb_ack),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_dat(wb_dat),
        .freeze(freeze),
        .rf_wr_addr(rf_wr_addr), .rf_wr_en(rf_wr_en), .rf_wr_data(rf_wr_data)
    );

endmodule

`default_nettype wire

// ==== sim/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_checker (
    input logic                           clk,
    input logic                           reset,
    input logic [riscv_isa_pkg::XLEN-1:0] imem_addr,
    input logic                           wb_cyc,
    input logic                           wb_stb,
    input logic                           wb_ack,
    input logic [riscv_isa_pkg::XLEN-1:0] wb_adr,
    input logic [riscv_isa_pkg::XLEN-1:0] wb_dat
);

    int fail_count = 0;

    stb_inside_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
        else begin
            fail_count++;
            $error("wb_stb high while wb_cyc is low");
        end

    // Write still waiting on the slave
    bus_held: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat)))
        else begin
            fail_count++;
            $error("wb_adr or wb_dat changed before wb_ack");
        end

    fetch_held: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> $stable(imem_addr))
        else begin
            fail_count++;
            $error("imem_addr moved while a write was waiting");
        end

    idle_in_reset: assert property (@(posedge clk) reset |-> !wb_cyc)
        else begin
            fail_count++;
            $error("wb_cyc high during reset");
        end

endmodule

bind riscv_ai_core core_checker u_checker (
    .clk(clk), .reset(reset), .imem_addr(imem_addr),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack), .wb_adr(wb_adr), .wb_dat(wb_dat)
);

`default_nettype wire

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    logic        clk;
    logic        reset;
    logic [31:0] imem_data;
    logic        wb_ack;
    logic [31:0] imem_addr;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;

    logic [31:0] prog [0:63];
    int          prog_len = 0;
    logic [31:0] ref_regs [0:31]; // Architectural state of the reference model
    logic [31:0] exp_adr_q [$];
    logic [31:0] exp_dat_q [$];
    logic [31:0] got_adr_q [$];
    logic [31:0] got_dat_q [$];
    logic [31:0] lcg_state = 32'hcd54707f;
    int          max_delay = 0;
    int          ack_delay = 0;
    int          wait_cnt = 0;
    int          budget_cycles = 0;
    int          cycle_cnt = 0;

    riscv_ai_core u_dut (
        .clk(clk), .reset(reset), .imem_data(imem_data), .wb_ack(wb_ack),
        .imem_addr(imem_addr), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_adr(wb_adr), .wb_dat(wb_dat)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Unused words hold NOPs
    always_comb begin
        imem_data = (imem_addr < 32'd256) ? prog[imem_addr[7:2]] : riscv_isa_pkg::NOP_INSTR;
    end

    // Wishbone slave, a delay of zero acks in the same cycle as stb
    assign wb_ack = wb_stb && (wait_cnt >= ack_delay);

    always @(posedge clk) begin
        if (reset) begin
            wait_cnt  <= 0;
            ack_delay <= 0;
        end else if (wb_stb && wb_ack) begin
            got_adr_q.push_back(wb_adr);
            got_dat_q.push_back(wb_dat);
            wait_cnt <= 0;
            if (max_delay > 0) begin
                lcg_state = lcg_next(lcg_state);
                ack_delay <= int'(lcg_state[26:24]) % (max_delay + 1);
            end
        end else if (wb_stb) begin
            wait_cnt <= wait_cnt + 1;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > budget_cycles + 60) begin
                $display("Timeout: the core made no progress within %0d cycles", cycle_cnt);
                $display("Checks failed");
                $fatal(1, "Watchdog expired");
            end
        end
    end

    // A failed assertion in the bound checker ends the run
    always @(negedge clk) begin
        if (u_dut.u_checker.fail_count != 0) begin
            $display("Checks failed");
            $fatal(1, "Bus or fetch protocol violated");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // Result of one ALU instruction as the ISA defines it
    function automatic logic [31:0] alu_ref(input logic [6:0] opc, input logic [2:0] f3,
                                            input logic [6:0] f7, input logic [31:0] a,
                                            input logic [31:0] b);
        longint prod;
        prod = longint'($signed(a)) * longint'($signed(b));
        if (opc == riscv_isa_pkg::OPC_CUSTOM0) begin
            case (f3)
                3'b000:  return prod[31:0];           // DOT
                3'b010:  return a[31] ? 32'd0 : a;    // RELU
                default: return {31'd0, ~a[31]};      // STEP
            endcase
        end
        case (f3)
            3'b000:  return (opc == riscv_isa_pkg::OPC_OP && f7 == 7'b0100000) ? a - b : a + b;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic put_word(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic put_r(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                         input int rd, input int rs1, input int rs2);
        put_word({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc});
        if (rd != 0) ref_regs[rd] = alu_ref(opc, f3, f7, ref_regs[rs1], ref_regs[rs2]);
    endtask

    task automatic put_i(input logic [2:0] f3, input int rd, input int rs1, input int imm);
        put_word({12'(imm), 5'(rs1), f3, 5'(rd), riscv_isa_pkg::OPC_OP_IMM});
        if (rd != 0) begin
            ref_regs[rd] = alu_ref(riscv_isa_pkg::OPC_OP_IMM, f3, 7'd0, ref_regs[rs1],
                                   sext12(12'(imm)));
        end
    endtask

    task automatic put_nn(input logic [2:0] f3, input int rd, input int rs1, input int rs2);
        put_r(riscv_isa_pkg::OPC_CUSTOM0, f3, 7'd0, rd, rs1, rs2);
    endtask

    task automatic put_sw(input int rs2, input int rs1, input int imm);
        logic [11:0] off;
        off = 12'(imm);
        put_word({off[11:5], 5'(rs2), 5'(rs1), riscv_isa_pkg::F3_SW, off[4:0],
                  riscv_isa_pkg::OPC_STORE});
        exp_adr_q.push_back(ref_regs[rs1] + sext12(off));
        exp_dat_q.push_back(ref_regs[rs2]);
    endtask

    task automatic begin_test(input int delay_max);
        max_delay = delay_max;
        prog_len = 0;
        for (int i = 0; i < 64; i++) prog[i] = riscv_isa_pkg::NOP_INSTR;
        for (int i = 0; i < 32; i++) ref_regs[i] = 32'd0;
        exp_adr_q.delete();
        exp_dat_q.delete();
        @(posedge clk);
        reset <= 1'b1;
    endtask

    task automatic release_reset();
        @(posedge clk);
        got_adr_q.delete();
        got_dat_q.delete();
        @(posedge clk);
        reset <= 1'b0;
        budget_cycles += (prog_len + 12) * 5;
        @(negedge clk);
    endtask

    task automatic run_and_check();
        int n;
        n = exp_adr_q.size();
        // Done once the PC is well past the last word and the pipe has drained
        while (imem_addr < 32'(4 * (prog_len + 7))) @(negedge clk);
        check_val("store count", 32'(got_adr_q.size()), 32'(n));
        for (int i = 0; i < n; i++) begin
            check_val("wb_adr", got_adr_q.pop_front(), exp_adr_q.pop_front());
            check_val("wb_dat", got_dat_q.pop_front(), exp_dat_q.pop_front());
        end
    endtask

    task automatic test_reset_fetch();
        begin_test(0);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 1, 0, 5);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 2, 1, 6);
        release_reset();
        for (int i = 0; i < 8; i++) begin
            check_val("imem_addr", imem_addr, 32'(4 * i));
            check_val("wb_cyc", 32'(wb_cyc), 32'd0);
            @(negedge clk);
        end
        run_and_check();
    endtask

    task automatic test_alu_chain();
        begin_test(0);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 1, 0, 12'h123);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 2, 1, -5);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_ADD_SUB, 7'd0, 3, 2, 1);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_ADD_SUB, riscv_isa_pkg::F7_SUB, 4, 1, 3);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_AND, 7'd0, 5, 4, 3);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_OR, 7'd0, 6, 5, 2);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_XOR, 7'd0, 7, 6, 4);
        put_i(riscv_isa_pkg::F3_AND, 8, 7, 12'h7f0);
        put_i(riscv_isa_pkg::F3_OR, 9, 8, -256);
        put_i(riscv_isa_pkg::F3_XOR, 10, 9, 12'h555);
        put_sw(10, 9, 16);                                 // Data from EX/MEM, base from MEM/WB
        put_i(riscv_isa_pkg::F3_ADD_SUB, 11, 0, 12'h400);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 12, 0, 7);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_ADD_SUB, 7'd0, 13, 11, 12);
        put_i(riscv_isa_pkg::F3_XOR, 14, 2, 12'h0f0);
        put_i(riscv_isa_pkg::F3_OR, 15, 3, 1);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_ADD_SUB, 7'd0, 16, 13, 15); // x13 via write-through
        for (int r = 16; r >= 1; r--) put_sw(r, 11, 4 * r);
        release_reset();
        run_and_check();
    endtask

    task automatic test_nn_ops();
        begin_test(0);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 1, 0, -7);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 2, 0, 1234);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 3, 0, 2047);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_ADD_SUB, 7'd0, 3, 3, 3);
        put_nn(riscv_isa_pkg::F3_DOT, 4, 3, 3);
        put_nn(riscv_isa_pkg::F3_DOT, 5, 4, 4);            // Wraps past 32 bits
        put_nn(riscv_isa_pkg::F3_DOT, 6, 1, 1);
        put_nn(riscv_isa_pkg::F3_DOT, 7, 1, 5);
        put_nn(riscv_isa_pkg::F3_DOT, 8, 2, 1);
        put_nn(riscv_isa_pkg::F3_RELU, 9, 1, 0);
        put_nn(riscv_isa_pkg::F3_RELU, 10, 0, 0);
        put_nn(riscv_isa_pkg::F3_RELU, 11, 2, 0);
        put_nn(riscv_isa_pkg::F3_RELU, 12, 5, 0);
        put_nn(riscv_isa_pkg::F3_STEP, 13, 1, 0);
        put_nn(riscv_isa_pkg::F3_STEP, 14, 0, 0);
        put_nn(riscv_isa_pkg::F3_STEP, 15, 2, 0);
        for (int r = 4; r <= 15; r++) put_sw(r, 0, 256 + 4 * r);
        release_reset();
        run_and_check();
    endtask

    task automatic test_ack_delays();
        begin_test(4);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 5, 0, 12'h200);
        for (int i = 0; i < 10; i++) begin
            put_i(riscv_isa_pkg::F3_ADD_SUB, 1 + i % 4, 1 + (i + 3) % 4, i * 37 - 100);
            put_sw(1 + i % 4, 5, 4 * i);
            if (i % 2 == 0) put_sw(1 + (i + 3) % 4, 5, 64 + 4 * i); // Back-to-back
        end
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_XOR, 7'd0, 6, 1, 2);
        put_sw(6, 5, 128);
        release_reset();
        run_and_check();
    endtask

    task automatic test_zero_reg();
        begin_test(0);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 1, 0, 3);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 2, 0, 5);
        put_i(riscv_isa_pkg::F3_ADD_SUB, 0, 0, 55);
        put_r(riscv_isa_pkg::OPC_OP, riscv_isa_pkg::F3_ADD_SUB, 7'd0, 3, 0, 1);
        put_nn(riscv_isa_pkg::F3_DOT, 0, 1, 2);
        put_sw(0, 2, 32);
        put_sw(1, 0, 36);
        put_word({12'h001, 5'd1, 3'd0, 5'd1, 7'b1111011}); // Undecoded, looks like addi x1
        put_sw(1, 0, 40);
        put_sw(3, 0, 44);
        release_reset();
        run_and_check();
    endtask

    initial begin
        reset = 1'b1;
        test_reset_fetch();
        test_alu_chain();
        test_nn_ops();
        test_ack_delays();
        test_zero_reg();
        if (u_dut.u_checker.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Assertion failures: %0d", u_dut.u_checker.fail_count);
            $display("Checks failed");
            $fatal(1, "Bus or fetch protocol violated");
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/riscv_isa_pkg.sv
rtl/core_cfg_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/riscv_ai_core.sv
sim/core_checker.sv
sim/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
        -f files.f -o core_tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/core_tb_sim +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "All checks passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
